/* mul_config.svh */
`ifndef MUL_CONFIG_SVH
`define MUL_CONFIG_SVH

// ########################################
// Multiplier sizing
// ########################################

`define MUL_XLEN     64  // Operand width
`define MUL_PP_NUM   33  // Radix-4 digits over XLEN+2 bits

// Accepting edge to done pulse, in cycles
`define MUL_LATENCY  4

`endif

/* mul_pkg.sv */
`include "mul_config.svh"

package mul_pkg;

    // ########################################
    // Request side
    // ########################################

    typedef enum logic [1:0] {
        MODE_UU  = 2'd0,  // Unsigned x unsigned
        MODE_SU  = 2'd1,  // Signed x unsigned
        MODE_SS  = 2'd2,  // Signed x signed
        MODE_RSV = 2'd3   // Reserved, zero product
    } mul_mode_e;

    typedef struct packed {
        mul_mode_e             mode;
        logic [`MUL_XLEN-1:0]  multiplicand;
        logic [`MUL_XLEN-1:0]  multiplier;
    } mul_req_t;

    // ########################################
    // Control and result
    // ########################################

    typedef enum logic [2:0] {IDLE, STAGE1, STAGE2, STAGE3, DONE} mul_state_e;

    typedef struct packed {
        logic [`MUL_XLEN-1:0]  hi;
        logic [`MUL_XLEN-1:0]  lo;
    } mul_rsp_t;

endpackage

/* booth_pkg.sv */
`include "mul_config.svh"

package booth_pkg;

    // Radix-4 digit action on the multiplicand
    typedef enum logic [2:0] {
        ZERO,
        POS_X,
        POS_2X,
        NEG_X,
        NEG_2X
    } booth_op_e;

    // Operands after sign or zero extension
    typedef struct packed {
        logic [2*`MUL_XLEN-1:0]  mcand;   // Full product width
        logic [`MUL_XLEN+1:0]    mplier;  // Two guard bits
    } ext_op_t;

    // One partial product row
    typedef struct packed {
        logic [2*`MUL_XLEN-1:0]  bits;
        logic                    neg;  // +1 completing the inversion
    } pp_t;

    // The neg flags are summed at bit 0 of the product, not at the row offset.
    // Inverting the whole 128-bit shifted row makes that valid.

endpackage

/* mul_control.sv */
`timescale 1ns/1ns

module mul_control (
    input  logic clk,
    input  logic rst,
    input  logic valid_in,
    output logic accept,
    output logic valid_out
);

    mul_pkg::mul_state_e state;
    mul_pkg::mul_state_e state_nxt;

    // Requests outside IDLE are dropped
    assign accept = valid_in && (state == mul_pkg::IDLE);

    always_comb begin
        case (state)
            mul_pkg::IDLE:   state_nxt = accept ? mul_pkg::STAGE1 : mul_pkg::IDLE;
            mul_pkg::STAGE1: state_nxt = mul_pkg::STAGE2;  // Partial products
            mul_pkg::STAGE2: state_nxt = mul_pkg::STAGE3;  // Column mid-stage
            mul_pkg::STAGE3: state_nxt = mul_pkg::DONE;    // Adder rows
            mul_pkg::DONE:   state_nxt = mul_pkg::IDLE;
            default:         state_nxt = mul_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= mul_pkg::IDLE;
            valid_out <= 1'b0;
        end else begin
            state     <= state_nxt;
            valid_out <= (state == mul_pkg::DONE);  // Lines up with rsp update
        end
    end

endmodule

/* mul_operand_extend.sv */
`timescale 1ns/1ns
`include "mul_config.svh"

module mul_operand_extend (
    input  logic                clk,
    input  logic                rst,
    input  logic                accept,
    input  mul_pkg::mul_req_t   req,
    output booth_pkg::ext_op_t  ext
);

    mul_pkg::mul_req_t req_q;

    logic a_sign;
    logic b_sign;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_q <= '0;
        end else if (accept) begin
            req_q <= req;
        end
    end

    assign a_sign = req_q.multiplicand[`MUL_XLEN-1];
    assign b_sign = req_q.multiplier[`MUL_XLEN-1];

    always_comb begin
        case (req_q.mode)
            mul_pkg::MODE_UU: begin
                ext.mcand  = {{`MUL_XLEN{1'b0}}, req_q.multiplicand};
                ext.mplier = {2'b00, req_q.multiplier};
            end
            mul_pkg::MODE_SU: begin
                ext.mcand  = {{`MUL_XLEN{a_sign}}, req_q.multiplicand};
                ext.mplier = {2'b00, req_q.multiplier};  // Multiplier stays unsigned
            end
            mul_pkg::MODE_SS: begin
                ext.mcand  = {{`MUL_XLEN{a_sign}}, req_q.multiplicand};
                ext.mplier = {{2{b_sign}}, req_q.multiplier};
            end
            default: begin
                ext.mcand  = '0;  // Reserved mode
                ext.mplier = '0;
            end
        endcase
    end

endmodule

/* booth_pp_gen.sv */
`timescale 1ns/1ns
`include "mul_config.svh"

module booth_pp_gen (
    input  logic [2:0]              digit,
    input  logic [2*`MUL_XLEN-1:0]  x,
    output booth_pkg::pp_t          pp
);

    booth_pkg::booth_op_e       op;
    logic [2*`MUL_XLEN-1:0]     mag;

    // Triplet is {b[2i+1], b[2i], b[2i-1]}
    always_comb begin
        case (digit)
            3'b000, 3'b111: op = booth_pkg::ZERO;
            3'b001, 3'b010: op = booth_pkg::POS_X;
            3'b011:         op = booth_pkg::POS_2X;
            3'b100:         op = booth_pkg::NEG_2X;
            default:        op = booth_pkg::NEG_X;  // 101, 110
        endcase
    end

    always_comb begin
        case (op)
            booth_pkg::POS_X, booth_pkg::NEG_X:   mag = x;
            booth_pkg::POS_2X, booth_pkg::NEG_2X: mag = x << 1;
            default:                              mag = '0;
        endcase
    end

    always_comb begin
        if (op == booth_pkg::NEG_X || op == booth_pkg::NEG_2X) begin
            pp.bits = ~mag;
            pp.neg  = 1'b1;  // Completes two's complement
        end else begin
            pp.bits = mag;
            pp.neg  = 1'b0;
        end
    end

endmodule

/* csa_column.sv */
`timescale 1ns/1ns
`include "mul_config.svh"

module csa_column (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`MUL_PP_NUM-1:0]  pp_bits,
    input  logic [10:0]             cin_l1,
    input  logic [6:0]              cin_l2,
    input  logic [4:0]              cin_l3,
    input  logic [2:0]              cin_l4,
    input  logic [1:0]              cin_l5,
    input  logic [1:0]              cin_l6,
    input  logic [0:0]              cin_l7,
    input  logic [0:0]              cin_l8,
    output logic [10:0]             cout_l1,
    output logic [6:0]              cout_l2,
    output logic [4:0]              cout_l3,
    output logic [2:0]              cout_l4,
    output logic [1:0]              cout_l5,
    output logic [1:0]              cout_l6,
    output logic [0:0]              cout_l7,
    output logic [0:0]              cout_l8,
    output logic                    sum,
    output logic                    carry
);

    logic [10:0] s1;
    logic [21:0] r1;
    logic [6:0]  s2;
    logic [14:0] r2;
    logic [4:0]  s3;
    logic [9:0]  r3;
    logic [2:0]  s4;
    logic [6:0]  r4;
    logic [6:0]  r4_q;
    logic [1:0]  s5;
    logic [4:0]  r5;
    logic [1:0]  s6;
    logic [3:0]  r6;
    logic        s7;
    logic [2:0]  r7;
    logic        s8;

    // 3:2 counter, returns {carry, sum}
    function automatic logic [1:0] fa(input logic a, input logic b, input logic c);
        fa = {(a & b) | (a & c) | (b & c), a ^ b ^ c};
    endfunction

    // ########################################
    // Levels 1 to 4, 33 -> 7
    // ########################################

    always_comb begin
        for (int i = 0; i < 11; i++) begin
            {cout_l1[i], s1[i]} = fa(pp_bits[3*i], pp_bits[3*i+1], pp_bits[3*i+2]);
        end
        r1 = {cin_l1, s1};
        for (int i = 0; i < 7; i++) begin
            {cout_l2[i], s2[i]} = fa(r1[3*i], r1[3*i+1], r1[3*i+2]);
        end
        r2 = {cin_l2, r1[21], s2};  // One bit passes
        for (int i = 0; i < 5; i++) begin
            {cout_l3[i], s3[i]} = fa(r2[3*i], r2[3*i+1], r2[3*i+2]);
        end
        r3 = {cin_l3, s3};
        for (int i = 0; i < 3; i++) begin
            {cout_l4[i], s4[i]} = fa(r3[3*i], r3[3*i+1], r3[3*i+2]);
        end
        r4 = {cin_l4, r3[9], s4};
    end

    // Mid-stage, same cut in every column
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            r4_q <= '0;
        end else begin
            r4_q <= r4;
        end
    end

    // ########################################
    // Levels 5 to 8, 7 -> 2
    // ########################################

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            {cout_l5[i], s5[i]} = fa(r4_q[3*i], r4_q[3*i+1], r4_q[3*i+2]);
        end
        r5 = {cin_l5, r4_q[6], s5};
        {cout_l6[0], s6[0]} = fa(r5[0], r5[1], r5[2]);
        {cout_l6[1], s6[1]} = fa(r5[3], r5[4], 1'b0);  // Only two bits left
        r6 = {cin_l6, s6};
        {cout_l7, s7} = fa(r6[0], r6[1], r6[2]);
        r7 = {cin_l7, r6[3], s7};
        {cout_l8, s8} = fa(r7[0], r7[1], r7[2]);
    end

    // Fold the last incoming carry so carry has weight j+1
    assign sum   = s8 ^ cin_l8[0];
    assign carry = s8 & cin_l8[0];

endmodule

/* mul_final_add.sv */
`timescale 1ns/1ns
`include "mul_config.svh"

module mul_final_add (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [2*`MUL_XLEN-1:0]   col_sum,
    input  logic [2*`MUL_XLEN-1:0]   col_carry,
    input  logic [1:0]               neg_tail,
    output mul_pkg::mul_rsp_t        rsp
);

    logic [2*`MUL_XLEN-1:0] row_a;
    logic [2*`MUL_XLEN-1:0] row_b;
    logic                   tail_q;
    logic [2*`MUL_XLEN-1:0] prod;

    // ########################################
    // Row register
    // ########################################

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            row_a  <= '0;
            row_b  <= '0;
            tail_q <= 1'b0;
        end else begin
            row_a  <= {col_carry[2*`MUL_XLEN-2:0], neg_tail[0]};  // Carries move up one
            row_b  <= col_sum;
            tail_q <= neg_tail[1];  // Last row's +1
        end
    end

    // ########################################
    // Carry-propagate add
    // ########################################

    assign prod = row_a + row_b + {{(2*`MUL_XLEN-1){1'b0}}, tail_q};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp <= '0;
        end else begin
            rsp <= mul_pkg::mul_rsp_t'(prod);
        end
    end

endmodule

/* booth_mul.sv */
`timescale 1ns/1ns
`include "mul_config.svh"

module booth_mul (
    input  logic               clk,
    input  logic               rst,
    input  logic               valid_in,
    input  mul_pkg::mul_req_t  req,
    output logic               valid_out,
    output mul_pkg::mul_rsp_t  rsp
);

    localparam int W = 2 * `MUL_XLEN;

    logic                    accept;
    booth_pkg::ext_op_t      ext;
    logic [`MUL_XLEN+2:0]    mplier_pad;
    booth_pkg::pp_t          pp   [`MUL_PP_NUM];
    booth_pkg::pp_t          pp_q [`MUL_PP_NUM];
    logic [`MUL_PP_NUM-1:0]  neg_q;
    logic [`MUL_PP_NUM-1:26] neg_mid;
    logic [`MUL_PP_NUM-1:0]  col_bits [W];
    logic [W-1:0]            col_sum;
    logic [W-1:0]            col_carry;

    // Index j feeds column j, column j drives j+1
    logic [10:0] c1 [W+1];
    logic [6:0]  c2 [W+1];
    logic [4:0]  c3 [W+1];
    logic [2:0]  c4 [W+1];
    logic [1:0]  c5 [W+1];
    logic [1:0]  c6 [W+1];
    logic [0:0]  c7 [W+1];
    logic [0:0]  c8 [W+1];

    mul_control u_mul_control (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (valid_in),
        .accept    (accept),
        .valid_out (valid_out)
    );

    mul_operand_extend u_mul_operand_extend (
        .clk    (clk),
        .rst    (rst),
        .accept (accept),
        .req    (req),
        .ext    (ext)
    );

    // ########################################
    // Booth generators and pp register
    // ########################################

    assign mplier_pad = {ext.mplier, 1'b0};  // Zero below bit 0

    for (genvar i = 0; i < `MUL_PP_NUM; i++) begin : g_pp
        booth_pp_gen u_booth_pp_gen (
            .digit (mplier_pad[2*i+2:2*i]),
            .x     (ext.mcand << (2*i)),
            .pp    (pp[i])
        );
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `MUL_PP_NUM; i++) begin
                pp_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `MUL_PP_NUM; i++) begin
                pp_q[i] <= pp[i];
            end
        end
    end

    // Transpose rows into columns
    always_comb begin
        for (int k = 0; k < `MUL_PP_NUM; k++) begin
            neg_q[k] = pp_q[k].neg;
            for (int j = 0; j < W; j++) begin
                col_bits[j][k] = pp_q[k].bits[j];
            end
        end
    end

    // Flags consumed after the column mid-stage
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            neg_mid <= '0;
        end else begin
            neg_mid <= neg_q[`MUL_PP_NUM-1:26];
        end
    end

    // ########################################
    // Wallace columns
    // ########################################

    // Column 0 takes the negate flags in place of neighbour carries
    assign c1[0] = neg_q[10:0];
    assign c2[0] = neg_q[17:11];
    assign c3[0] = neg_q[22:18];
    assign c4[0] = neg_q[25:23];
    assign c5[0] = neg_mid[27:26];
    assign c6[0] = neg_mid[29:28];
    assign c7[0] = neg_mid[30];
    assign c8[0] = 1'b0;

    for (genvar j = 0; j < W; j++) begin : g_col
        csa_column u_csa_column (
            .clk     (clk),
            .rst     (rst),
            .pp_bits (col_bits[j]),
            .cin_l1  (c1[j]),
            .cin_l2  (c2[j]),
            .cin_l3  (c3[j]),
            .cin_l4  (c4[j]),
            .cin_l5  (c5[j]),
            .cin_l6  (c6[j]),
            .cin_l7  (c7[j]),
            .cin_l8  (c8[j]),
            .cout_l1 (c1[j+1]),
            .cout_l2 (c2[j+1]),
            .cout_l3 (c3[j+1]),
            .cout_l4 (c4[j+1]),
            .cout_l5 (c5[j+1]),
            .cout_l6 (c6[j+1]),
            .cout_l7 (c7[j+1]),
            .cout_l8 (c8[j+1]),
            .sum     (col_sum[j]),
            .carry   (col_carry[j])
        );
    end

    mul_final_add u_mul_final_add (
        .clk       (clk),
        .rst       (rst),
        .col_sum   (col_sum),
        .col_carry (col_carry),
        .neg_tail  (neg_mid[32:31]),
        .rsp       (rsp)
    );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk
);

    localparam int HALF_PERIOD = 20;  // 40 ns period

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

/* tb_booth_mul.sv */
`timescale 1ns/1ns
`include "mul_config.svh"

module tb_booth_mul;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_VEC      = 64;
    localparam int FIELDS       = 5;  // Mode, a, b, hi, lo

    logic                    clk;
    logic                    rst;
    logic                    valid_in;
    mul_pkg::mul_req_t       req;
    logic                    valid_out;
    mul_pkg::mul_rsp_t       rsp;

    logic [`MUL_XLEN-1:0]    golden [FIELDS*MAX_VEC];
    int                      vec_count;
    bit                      loaded;
    int                      error_count;
    logic [2*`MUL_XLEN-1:0]  last_product;  // Value rsp must hold

    tb_clock_gen u_tb_clock_gen (
        .clk (clk)
    );

    booth_mul u_booth_mul (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (valid_in),
        .req       (req),
        .valid_out (valid_out),
        .rsp       (rsp)
    );

    // ########################################
    // Error reporting
    // ########################################

    task automatic report_mismatch(input string name, input logic [2*`MUL_XLEN-1:0] expected,
                                   input logic [2*`MUL_XLEN-1:0] actual);
        error_count++;
        $display("** Error: %s expected %0h actual %0h", name, expected, actual);
        $display("Simulation failed");
        $fatal(1, "Stopped at first mismatch");
    endtask

    task automatic report_problem(input string what);
        error_count++;
        $display("** Error: %s", what);
        $display("Simulation failed");
        $fatal(1, "Stopped at first error");
    endtask

    // One idle cycle, no pulse and rsp unchanged
    task automatic check_idle(input string name);
        @(negedge clk);
        assert (valid_out === 1'b0) else report_mismatch({name, " valid_out"}, '0, valid_out);
        assert (rsp === last_product) else report_mismatch({name, " hold"}, last_product, rsp);
    endtask

    // ########################################
    // One request, optional dropped second strobe
    // ########################################

    task automatic run_vector(input int idx);
        logic [1:0]              mode;
        logic [2*`MUL_XLEN-1:0]  expected;
        string                   name;
        int                      lat;
        bit                      do_drop;
        int                      drop_lat;
        mode     = golden[FIELDS*idx][1:0];
        expected = {golden[FIELDS*idx+3], golden[FIELDS*idx+4]};
        name     = $sformatf("vector %0d mode %0d", idx, mode);
        do_drop  = (idx % 3 == 1);
        drop_lat = (idx / 3) % 3;  // Lands 1 to 3 cycles after accept
        @(negedge clk);
        valid_in         = 1'b1;
        req.mode         = mul_pkg::mul_mode_e'(mode);
        req.multiplicand = golden[FIELDS*idx+1];
        req.multiplier   = golden[FIELDS*idx+2];
        @(negedge clk);
        valid_in = 1'b0;
        lat = 0;
        while (valid_out !== 1'b1) begin
            assert (lat < `MUL_LATENCY) else report_mismatch({name, " latency"}, `MUL_LATENCY, lat);
            assert (rsp === last_product) else report_mismatch({name, " hold"}, last_product, rsp);
            if (do_drop && lat == drop_lat) begin
                valid_in         = 1'b1;  // Unit busy, must be ignored
                req.mode         = mul_pkg::MODE_UU;
                req.multiplicand = ~req.multiplicand;
                req.multiplier   = ~req.multiplier;
            end else begin
                valid_in = 1'b0;
            end
            @(negedge clk);
            lat++;
        end
        valid_in = 1'b0;
        assert (lat == `MUL_LATENCY) else report_mismatch({name, " latency"}, `MUL_LATENCY, lat);
        assert (rsp === expected) else report_mismatch(name, expected, rsp);
        if (mode == mul_pkg::MODE_RSV) begin
            assert (rsp === '0) else report_mismatch({name, " reserved"}, '0, rsp);
        end
        last_product = expected;
        check_idle({name, " pulse width"});
    endtask

    // ########################################
    // Main sequence
    // ########################################

    initial begin
        int gap;
        rst          = 1'b1;
        valid_in     = 1'b0;
        req          = '0;
        error_count  = 0;
        last_product = '0;
        loaded       = 1'b0;
        vec_count    = 0;
        void'($urandom(1));
        $readmemh("booth_mul_golden.txt", golden);
        while (vec_count < MAX_VEC && !$isunknown(golden[FIELDS*vec_count])) begin
            vec_count++;
        end
        if (vec_count == 0) begin
            report_problem("no vectors could be read from booth_mul_golden.txt");
        end
        loaded = 1'b1;
        repeat (RESET_CYCLES) check_idle("reset");
        rst = 1'b0;
        repeat (2) check_idle("after reset");
        for (int i = 0; i < vec_count; i++) begin
            run_vector(i);
            gap = $urandom % 4;
            repeat (gap) check_idle($sformatf("gap after vector %0d", i));
        end
        repeat (4) check_idle("tail");
        if (error_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "Errors found");
        end
    end

    // Watchdog, sized from the vector count
    initial begin
        wait (loaded);
        #((vec_count * 10 + RESET_CYCLES) * CLK_PERIOD);
        $display("** Error: watchdog timeout, the run did not finish in time");
        $display("Simulation failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

/* booth_mul_golden.txt */
// mode multiplicand multiplier product_hi product_lo, all hex
// mode 0 unsigned, 1 signed x unsigned, 2 signed, 3 reserved
0 0000000000000000 0000000000000000 0000000000000000 0000000000000000
0 0000000000000000 FFFFFFFFFFFFFFFF 0000000000000000 0000000000000000
0 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFE 0000000000000001
0 0000000000000001 FFFFFFFFFFFFFFFF 0000000000000000 FFFFFFFFFFFFFFFF
0 0000000000000002 8000000000000000 0000000000000001 0000000000000000
0 00000000FFFFFFFF 00000000FFFFFFFF 0000000000000000 FFFFFFFE00000001
0 0000000100000000 0000000100000000 0000000000000001 0000000000000000
0 123456789ABCDEF0 0000000000000010 0000000000000001 23456789ABCDEF00
0 0000000000000003 5555555555555555 0000000000000000 FFFFFFFFFFFFFFFF
0 FFFFFFFFFFFFFFFF 0000000000000002 0000000000000001 FFFFFFFFFFFFFFFE
1 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 0000000000000001
1 8000000000000000 FFFFFFFFFFFFFFFF 8000000000000000 8000000000000000
1 7FFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 7FFFFFFFFFFFFFFE 8000000000000001
1 FFFFFFFFFFFFFFFE 0000000000000003 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFA
1 0000000000000005 8000000000000000 0000000000000002 8000000000000000
1 FFFFFFFFFFFFFFFF 8000000000000000 FFFFFFFFFFFFFFFF 8000000000000000
1 123456789ABCDEF0 0000000000000100 0000000000000012 3456789ABCDEF000
1 0000000000000000 FFFFFFFFFFFFFFFF 0000000000000000 0000000000000000
2 8000000000000000 8000000000000000 4000000000000000 0000000000000000
2 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 0000000000000000 0000000000000001
2 7FFFFFFFFFFFFFFF 7FFFFFFFFFFFFFFF 3FFFFFFFFFFFFFFF 0000000000000001
2 8000000000000000 7FFFFFFFFFFFFFFF C000000000000000 8000000000000000
2 FFFFFFFFFFFFFFFD 0000000000000007 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFEB
2 FFFFFFFFFFFFFFFF 8000000000000000 0000000000000000 8000000000000000
2 FFFFFFFF00000000 0000000100000000 FFFFFFFFFFFFFFFF 0000000000000000
2 123456789ABCDEF0 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF EDCBA98765432110
2 0000000000000000 8000000000000000 0000000000000000 0000000000000000
3 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 0000000000000000 0000000000000000
3 123456789ABCDEF0 0FEDCBA987654321 0000000000000000 0000000000000000
3 8000000000000000 0000000000000001 0000000000000000 0000000000000000

/* booth_mul.f */
+incdir+.
mul_pkg.sv
booth_pkg.sv
mul_control.sv
mul_operand_extend.sv
booth_pp_gen.sv
csa_column.sv
mul_final_add.sv
booth_mul.sv
tb_clock_gen.sv
tb_booth_mul.sv

/* Bender.yml */
package:
  name: booth_mul

sources:
  - include_dirs:
      - .
    files:
      - mul_pkg.sv
      - booth_pkg.sv
      - mul_control.sv
      - mul_operand_extend.sv
      - booth_pp_gen.sv
      - csa_column.sv
      - mul_final_add.sv
      - booth_mul.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - tb_booth_mul.sv
